/* tlb_maint.f */
hw/tlb_maint_pkg.sv
hw/tlb_cmd_accept.sv
hw/tlb_write_seq.sv
hw/tlb_sweep_seq.sv
hw/tlb_req_build.sv
hw/tlb_maint_top.sv
tests/tb_tlb_maint.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_tlb_maint
FILELIST  ?= tlb_maint.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# a crashed run also counts as a failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
	  echo "simulation FAILED"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_tlb_maint.sv */
// ====================
// testbench for the jTLB maintenance sequencer
// jTLB model grants 0 to 3 cycles after a request, completes 1 to 2 after grant
// model ASID table decides asid_hit on every read
// request levels are dropped one edge after their completion pulse
// ====================
`timescale 1ns/1ps

module tb_tlb_maint;

  localparam int INVALL_LAST     = 63;
  localparam int INVASID_LAST    = 127;
  // one ASID sweep needs up to about 128 x 12 cycles, the rest is far shorter
  localparam int WATCHDOG_CYCLES = 20000;
  localparam logic [tlb_maint_pkg::ASID_WIDTH-1:0] CP0_ASID = 16'h3a5c;

  typedef enum {M_IDLE, M_GNT, M_CMP} model_st_e;

  logic                                 tlboper_clk;
  logic                                 cpurst_b;
  logic                                 regs_tlbwi;
  logic                                 regs_invall;
  logic                                 regs_invasid;
  logic                                 cp0_all_inv;
  logic                                 cp0_asid_inv;
  logic [tlb_maint_pkg::IDX_WIDTH-1:0]  regs_mir;
  tlb_maint_pkg::tlb_tag_t              cur_tag_fields;
  tlb_maint_pkg::tlb_data_t             cur_data;
  logic [tlb_maint_pkg::ASID_WIDTH-1:0] regs_inv_asid;
  logic [tlb_maint_pkg::ASID_WIDTH-1:0] cp0_asid;
  tlb_maint_pkg::jtlb_rsp_t             jtlb_rsp;
  tlb_maint_pkg::jtlb_req_t             jtlb_req;
  logic [tlb_maint_pkg::ASID_WIDTH-1:0] jtlb_inv_asid;
  logic                                 cmplt;
  logic                                 regs_cmplt;
  logic                                 cp0_inv_done;

  // jTLB model state
  logic [tlb_maint_pkg::ASID_WIDTH-1:0] asid_table [0:511];
  model_st_e                            m_state;
  int                                   gnt_wait;
  int                                   cmp_wait;
  tlb_maint_pkg::jtlb_req_t             snap;
  tlb_maint_pkg::jtlb_req_t             acc;
  logic [tlb_maint_pkg::ASID_WIDTH-1:0] snap_asid;
  logic                                 acc_pending;
  logic                                 acc_hit;
  int                                   seed;

  // expected values and counters
  int                                   test_id;
  int                                   err_cnt;
  int                                   err_base;
  int                                   tests_done;
  int                                   wr_count;
  int                                   rd_count;
  int                                   regs_cmplt_cnt;
  int                                   cp0_done_cnt;
  int                                   exp_hits;
  logic [tlb_maint_pkg::IDX_WIDTH-1:0]  exp_idx;
  logic [tlb_maint_pkg::IDX_WIDTH-1:0]  last_rd_idx;
  tlb_maint_pkg::tlb_tag_t              exp_tag;
  logic [1:0]                           exp_bank;
  logic [63:0]                          rnd;
  logic                                 gnt;
  logic                                 any_level;

  assign gnt       = jtlb_req.req && jtlb_rsp.grant;
  assign any_level = regs_tlbwi || regs_invall || regs_invasid || cp0_all_inv || cp0_asid_inv;

  tlb_maint_top #(
    .INVALL_LAST (INVALL_LAST),
    .INVASID_LAST(INVASID_LAST)
  ) DUT (
    .tlboper_clk   (tlboper_clk),   .cpurst_b     (cpurst_b),
    .regs_tlbwi    (regs_tlbwi),    .regs_invall  (regs_invall),
    .regs_invasid  (regs_invasid),  .cp0_all_inv  (cp0_all_inv),
    .cp0_asid_inv  (cp0_asid_inv),  .regs_mir     (regs_mir),
    .cur_tag_fields(cur_tag_fields), .cur_data    (cur_data),
    .regs_inv_asid (regs_inv_asid), .cp0_asid     (cp0_asid),
    .jtlb_rsp      (jtlb_rsp),      .jtlb_req     (jtlb_req),
    .jtlb_inv_asid (jtlb_inv_asid), .cmplt        (cmplt),
    .regs_cmplt    (regs_cmplt),    .cp0_inv_done (cp0_inv_done)
  );

  always #50 tlboper_clk = ~tlboper_clk;

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic log_access(input tlb_maint_pkg::jtlb_req_t a);
    if (a.write)
      wr_count++;
    else
    begin
      rd_count++;
      last_rd_idx = a.idx;
    end
    // sweep index moves on after each read or all-invalidate write
    if (!a.write || a.fifo_write)
      exp_idx = exp_idx - 1'b1;
  endtask

  // ====================
  // jTLB model
  // ====================
  always
  begin
    @(posedge tlboper_clk);
    #2;
    if (acc_pending)
    begin
      log_access(acc);
      acc_pending = 1'b0;
    end
    snap      = jtlb_req;
    snap_asid = jtlb_inv_asid;
    #3;
    jtlb_rsp.grant    = 1'b0;
    jtlb_rsp.cmplt    = 1'b0;
    jtlb_rsp.asid_hit = 1'b0;
    if (!cpurst_b)
      m_state = M_IDLE;
    else
    begin
      if (m_state == M_IDLE && snap.req)
      begin
        gnt_wait = $unsigned($random(seed)) % 4;
        m_state  = M_GNT;
      end
      if (m_state == M_GNT)
      begin
        if (gnt_wait == 0)
        begin
          jtlb_rsp.grant = 1'b1;
          acc            = snap;
          acc_pending    = 1'b1;
          acc_hit        = !snap.write && (asid_table[snap.idx] == snap_asid);
          cmp_wait       = 1 + $unsigned($random(seed)) % 2;
          m_state        = M_CMP;
        end
        else
          gnt_wait = gnt_wait - 1;
      end
      else if (m_state == M_CMP)
      begin
        cmp_wait = cmp_wait - 1;
        if (cmp_wait == 0)
        begin
          jtlb_rsp.cmplt    = 1'b1;
          jtlb_rsp.asid_hit = acc_hit;
          m_state           = M_IDLE;
        end
      end
    end
  end

  // pulses counted mid-cycle
  always @(negedge tlboper_clk)
  begin
    if (regs_cmplt)
      regs_cmplt_cnt++;
    if (cp0_inv_done)
      cp0_done_cnt++;
  end

  // ====================
  // checks
  // ====================
  quiet_when_idle: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    !any_level |-> !(jtlb_req.req || cmplt || regs_cmplt || cp0_inv_done))
    else report_mismatch("request or pulse active with no request level");

  req_held_stable: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (jtlb_req.req && !jtlb_rsp.grant) |=> $stable(jtlb_req))
    else report_mismatch("jtlb request changed before grant");

  wi_access_ok: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 2 && gnt) |-> (jtlb_req.write && !jtlb_req.fifo_write
      && jtlb_req.idx == regs_mir && jtlb_req.tag == exp_tag
      && jtlb_req.data == cur_data && jtlb_req.bank_sel == exp_bank))
    else report_mismatch("write-indexed access has wrong fields");

  wi_single: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 2 && regs_cmplt) |-> (wr_count == 1 && rd_count == 0 && regs_cmplt_cnt == 1))
    else report_mismatch("write-indexed access count or completion count wrong");

  invall_access_ok: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 3 && gnt) |-> (jtlb_req.write && jtlb_req.fifo_write
      && jtlb_req.fifo_din == 2'b01 && jtlb_req.bank_sel == 2'b11
      && jtlb_req.tag == '0 && jtlb_req.data == '0 && jtlb_req.idx == exp_idx))
    else report_mismatch("all-invalidate write has wrong fields or order");

  invall_count: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 3 && regs_cmplt) |-> (wr_count == INVALL_LAST + 1 && regs_cmplt_cnt == 1))
    else report_mismatch("all-invalidate write count or completion count wrong");

  asid_read_ok: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 4 && gnt && !jtlb_req.write) |-> (jtlb_req.idx == exp_idx
      && jtlb_req.bank_sel == (jtlb_req.idx[tlb_maint_pkg::BANK_BIT] ? 2'b10 : 2'b01)
      && jtlb_inv_asid == cp0_asid))
    else report_mismatch("ASID sweep read has wrong index, bank or ASID");

  asid_write_ok: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 4 && gnt && jtlb_req.write) |-> (jtlb_req.tag == '0 && jtlb_req.data == '0
      && !jtlb_req.fifo_write && jtlb_req.idx == last_rd_idx
      && asid_table[jtlb_req.idx] == cp0_asid))
    else report_mismatch("ASID sweep write at wrong entry or with nonzero fields");

  asid_no_regs: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 4) |-> !regs_cmplt)
    else report_mismatch("regs_cmplt pulsed for a CP0 operation");

  asid_count: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 4 && cp0_inv_done) |-> (rd_count == INVASID_LAST + 1
      && wr_count == exp_hits && cp0_done_cnt == 1))
    else report_mismatch("ASID sweep read, write or done count wrong");

  cp0_first: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 5 && cp0_all_inv && jtlb_req.req) |-> jtlb_req.fifo_write)
    else report_mismatch("register write started while CP0 level held");

  cp0_done_once: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 5 && cp0_inv_done) |-> (cp0_done_cnt == 1 && regs_cmplt_cnt == 0
      && wr_count == INVALL_LAST + 1))
    else report_mismatch("CP0 operation done count or write count wrong");

  regs_after_cp0: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (test_id == 5 && regs_cmplt) |-> (cp0_done_cnt == 1 && regs_cmplt_cnt == 1
      && wr_count == INVALL_LAST + 2))
    else report_mismatch("register operation did not follow the CP0 done once");

  // ====================
  // stimulus
  // ====================
  task automatic step_cycles(input int n);
    repeat (n) @(posedge tlboper_clk);
    #5;
  endtask

  task automatic wait_regs_cmplt();
    do
      @(negedge tlboper_clk);
    while (!regs_cmplt);
    @(posedge tlboper_clk);
    #5;
  endtask

  task automatic wait_cp0_done();
    do
      @(negedge tlboper_clk);
    while (!cp0_inv_done);
    @(posedge tlboper_clk);
    #5;
  endtask

  task automatic begin_test(input int id);
    test_id        = id;
    err_base       = err_cnt;
    wr_count       = 0;
    rd_count       = 0;
    regs_cmplt_cnt = 0;
    cp0_done_cnt   = 0;
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %0d %s: %0d errors", test_id, name, err_cnt - err_base);
    test_id = 0;
  endtask

  task automatic run_write_idx(input logic [tlb_maint_pkg::IDX_WIDTH-1:0] mir);
    begin_test(2);
    rnd            = {$random(seed), $random(seed)};
    regs_mir       = mir;
    cur_tag_fields = rnd[47:0];
    // valid input bit is ignored by the DUT
    cur_tag_fields.valid = 1'b0;
    rnd            = {$random(seed), $random(seed)};
    cur_data       = rnd[43:0];
    exp_tag        = cur_tag_fields;
    exp_tag.valid  = 1'b1;
    exp_bank       = mir[tlb_maint_pkg::BANK_BIT] ? 2'b10 : 2'b01;
    regs_tlbwi     = 1'b1;
    wait_regs_cmplt();
    regs_tlbwi     = 1'b0;
    step_cycles(3);
    end_test("write indexed");
  endtask

  initial
  begin
    seed           = 32'h89fde20d;
    tlboper_clk    = 1'b0;
    cpurst_b       = 1'b0;
    regs_tlbwi     = 1'b0;
    regs_invall    = 1'b0;
    regs_invasid   = 1'b0;
    cp0_all_inv    = 1'b0;
    cp0_asid_inv   = 1'b0;
    regs_mir       = '0;
    cur_tag_fields = '0;
    cur_data       = '0;
    regs_inv_asid  = ~CP0_ASID;
    cp0_asid       = CP0_ASID;
    jtlb_rsp       = '0;
    jtlb_rsp.tc_read = 1'b1;
    m_state        = M_IDLE;
    acc_pending    = 1'b0;
    test_id        = 0;
    err_cnt        = 0;
    tests_done     = 0;
    exp_idx        = '0;
    last_rd_idx    = '0;
    // about 3 in 8 entries carry the CP0 ASID, the rest differ by index
    for (int i = 0; i < 512; i++)
    begin
      if (($random(seed) & 7) < 3)
        asid_table[i] = CP0_ASID;
      else
        asid_table[i] = CP0_ASID ^ 16'(i + 1);
    end
    repeat (5) @(posedge tlboper_clk);
    #5;
    cpurst_b = 1'b1;

    begin_test(1);
    step_cycles(10);
    end_test("idle after reset");

    run_write_idx(9'h15a);
    run_write_idx(9'h0a5);

    begin_test(3);
    exp_idx     = 9'(INVALL_LAST);
    regs_invall = 1'b1;
    wait_regs_cmplt();
    regs_invall = 1'b0;
    step_cycles(3);
    end_test("invalidate all from registers");

    begin_test(4);
    exp_idx  = 9'(INVASID_LAST);
    exp_hits = 0;
    for (int i = 0; i <= INVASID_LAST; i++)
    begin
      if (asid_table[i] == CP0_ASID)
        exp_hits++;
    end
    cp0_asid_inv = 1'b1;
    wait_cp0_done();
    cp0_asid_inv = 1'b0;
    step_cycles(3);
    end_test("invalidate by ASID from CP0");

    // CP0 level and register level raised together
    begin_test(5);
    cp0_all_inv = 1'b1;
    regs_tlbwi  = 1'b1;
    wait_cp0_done();
    cp0_all_inv = 1'b0;
    wait_regs_cmplt();
    regs_tlbwi  = 1'b0;
    step_cycles(3);
    end_test("CP0 priority over registers");

    $display("summary: %0d tests run, %0d checks failed", tests_done, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge tlboper_clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

/* hw/tlb_maint_top.sv */
// ====================
// jTLB maintenance sequencer top: accept, sequencers, request build
// request levels are held until their completion pulse
// jTLB port is single, one operation in flight
// ====================
`timescale 1ns/1ps

module tlb_maint_top #(
  parameter int INVALL_LAST  = 63,
  parameter int INVASID_LAST = 127
) (
  input  logic                                 tlboper_clk,
  input  logic                                 cpurst_b,
  input  logic                                 regs_tlbwi,
  input  logic                                 regs_invall,
  input  logic                                 regs_invasid,
  input  logic                                 cp0_all_inv,
  input  logic                                 cp0_asid_inv,
  input  logic [tlb_maint_pkg::IDX_WIDTH-1:0]  regs_mir,
  input  tlb_maint_pkg::tlb_tag_t              cur_tag_fields,
  input  tlb_maint_pkg::tlb_data_t             cur_data,
  input  logic [tlb_maint_pkg::ASID_WIDTH-1:0] regs_inv_asid,
  input  logic [tlb_maint_pkg::ASID_WIDTH-1:0] cp0_asid,
  input  tlb_maint_pkg::jtlb_rsp_t             jtlb_rsp,
  output tlb_maint_pkg::jtlb_req_t             jtlb_req,
  output logic [tlb_maint_pkg::ASID_WIDTH-1:0] jtlb_inv_asid,
  output logic                                 cmplt,
  output logic                                 regs_cmplt,
  output logic                                 cp0_inv_done
);

  tlb_maint_pkg::tlb_start_t start;
  tlb_maint_pkg::seq_req_t   wi_req;
  tlb_maint_pkg::seq_req_t   sweep_req;
  logic                      wi_busy;
  logic                      sweep_busy;
  logic                      wi_done;
  logic                      sweep_done;
  logic                      regs_invasid_sel;

  // register ASID only when no CP0 level holds the port
  assign regs_invasid_sel = regs_invasid && !(cp0_all_inv || cp0_asid_inv);

  tlb_cmd_accept x_accept (
    .tlboper_clk (tlboper_clk),  .cpurst_b     (cpurst_b),
    .regs_tlbwi  (regs_tlbwi),   .regs_invall  (regs_invall),
    .regs_invasid(regs_invasid), .cp0_all_inv  (cp0_all_inv),
    .cp0_asid_inv(cp0_asid_inv), .wi_busy      (wi_busy),
    .sweep_busy  (sweep_busy),   .wi_done      (wi_done),
    .sweep_done  (sweep_done),   .start        (start),
    .cmplt       (cmplt),        .regs_cmplt   (regs_cmplt),
    .cp0_inv_done(cp0_inv_done)
  );

  tlb_write_seq x_write_seq (
    .tlboper_clk(tlboper_clk),    .cpurst_b(cpurst_b),
    .start_wi   (start.start_wi), .regs_mir(regs_mir),
    .jtlb_rsp   (jtlb_rsp),       .seq_req (wi_req),
    .busy       (wi_busy),        .done    (wi_done)
  );

  tlb_sweep_seq #(
    .INVALL_LAST (INVALL_LAST),
    .INVASID_LAST(INVASID_LAST)
  ) x_sweep_seq (
    .tlboper_clk(tlboper_clk),     .cpurst_b  (cpurst_b),
    .start_all  (start.start_all), .start_asid(start.start_asid),
    .jtlb_rsp   (jtlb_rsp),        .seq_req   (sweep_req),
    .busy       (sweep_busy),      .done      (sweep_done)
  );

  tlb_req_build x_req_build (
    .wi_req          (wi_req),           .sweep_req    (sweep_req),
    .cur_tag_fields  (cur_tag_fields),   .cur_data     (cur_data),
    .regs_invasid_sel(regs_invasid_sel), .regs_inv_asid(regs_inv_asid),
    .cp0_asid        (cp0_asid),         .jtlb_req     (jtlb_req),
    .jtlb_inv_asid   (jtlb_inv_asid)
  );

endmodule

/* hw/tlb_req_build.sv */
// ====================
// merges the sequencer requests into one jTLB request, no latency
// only one sequencer requests at a time
// tag and data are zero on invalidates
// ====================
`timescale 1ns/1ps

module tlb_req_build (
  input  tlb_maint_pkg::seq_req_t                  wi_req,
  input  tlb_maint_pkg::seq_req_t                  sweep_req,
  input  tlb_maint_pkg::tlb_tag_t                  cur_tag_fields,
  input  tlb_maint_pkg::tlb_data_t                 cur_data,
  input  logic                                     regs_invasid_sel,
  input  logic [tlb_maint_pkg::ASID_WIDTH-1:0]     regs_inv_asid,
  input  logic [tlb_maint_pkg::ASID_WIDTH-1:0]     cp0_asid,
  output tlb_maint_pkg::jtlb_req_t                 jtlb_req,
  output logic [tlb_maint_pkg::ASID_WIDTH-1:0]     jtlb_inv_asid
);

  tlb_maint_pkg::seq_req_t src;
  tlb_maint_pkg::tlb_op_e  op;
  logic [1:0]              idx_bank;

  assign src = sweep_req.req ? sweep_req : wi_req;

  // operation of the active request
  always_comb
  begin
    if (!src.req)
      op = tlb_maint_pkg::OP_NONE;
    else if (!src.src_sweep)
      op = tlb_maint_pkg::OP_WRITE_IDX;
    else if (src.fifo_write)
      op = tlb_maint_pkg::OP_INV_ALL;
    else
      op = tlb_maint_pkg::OP_INV_ASID;
  end

  // bank 1 holds indices with bit 6 set
  assign idx_bank = {src.idx[tlb_maint_pkg::BANK_BIT], !src.idx[tlb_maint_pkg::BANK_BIT]};

  always_comb
  begin
    jtlb_req            = '0;
    jtlb_req.req        = src.req;
    jtlb_req.write      = src.write;
    jtlb_req.fifo_write = src.fifo_write;
    jtlb_req.idx        = src.idx;
    case (op)
      tlb_maint_pkg::OP_WRITE_IDX:
      begin
        jtlb_req.bank_sel  = idx_bank;
        jtlb_req.tag       = cur_tag_fields;
        jtlb_req.tag.valid = 1'b1;
        jtlb_req.data      = cur_data;
      end
      tlb_maint_pkg::OP_INV_ALL:
      begin
        // both banks at once, FIFO bits back to 01
        jtlb_req.bank_sel = 2'b11;
        jtlb_req.fifo_din = 2'b01;
      end
      tlb_maint_pkg::OP_INV_ASID:
        jtlb_req.bank_sel = idx_bank;
      default:
        jtlb_req.bank_sel = 2'b00;
    endcase
  end

  // compare value for the jTLB ASID hit
  assign jtlb_inv_asid = regs_invasid_sel ? regs_inv_asid : cp0_asid;

  always_comb
  begin
    a_one_source: assert (!(wi_req.req === 1'b1 && sweep_req.req === 1'b1))
      else $error("req_build: write and sweep sequencers request together");
  end

endmodule

/* hw/tlb_sweep_seq.sv */
// ====================
// invalidate-all and invalidate-by-ASID sweeps over one down counter
// all-invalidate writes back to back, one per grant, and waits only
// for the last completion
// ASID sweep waits for the completion of every read, and a hit write
// moves on at grant except at index 0
// ====================
`timescale 1ns/1ps

module tlb_sweep_seq #(
  parameter int INVALL_LAST  = 63,
  parameter int INVASID_LAST = 127
) (
  input  logic                     tlboper_clk,
  input  logic                     cpurst_b,
  input  logic                     start_all,
  input  logic                     start_asid,
  input  tlb_maint_pkg::jtlb_rsp_t jtlb_rsp,
  output tlb_maint_pkg::seq_req_t  seq_req,
  output logic                     busy,
  output logic                     done
);

  typedef enum logic [1:0] {
    IALL_IDLE,
    IALL_WFG,
    IALL_FIN
  } iall_st_e;

  typedef enum logic [2:0] {
    IASID_IDLE,
    IASID_RD,
    IASID_RWC,
    IASID_WT,
    IASID_WWC
  } iasid_st_e;

  iall_st_e                            iall_st;
  iall_st_e                            iall_nxt;
  iasid_st_e                           iasid_st;
  iasid_st_e                           iasid_nxt;
  logic [tlb_maint_pkg::IDX_WIDTH-1:0] inv_cnt;
  logic                                cnt_zero;
  logic                                cnt_init;
  logic                                cnt_dec;
  logic                                rd_cmplt;

  assign cnt_zero = (inv_cnt == '0);
  assign rd_cmplt = jtlb_rsp.cmplt && jtlb_rsp.tc_read;

  // ====================
  // all-invalidate FSM
  // ====================
  always_comb
  begin
    iall_nxt = iall_st;
    case (iall_st)
      IALL_IDLE:
        if (start_all)
          iall_nxt = IALL_WFG;
      IALL_WFG:
        if (jtlb_rsp.grant && cnt_zero)
          iall_nxt = IALL_FIN;
      IALL_FIN:
        if (jtlb_rsp.cmplt)
          iall_nxt = IALL_IDLE;
      default:
        iall_nxt = IALL_IDLE;
    endcase
  end

  // ====================
  // ASID sweep FSM
  // ====================
  always_comb
  begin
    iasid_nxt = iasid_st;
    case (iasid_st)
      IASID_IDLE:
        if (start_asid)
          iasid_nxt = IASID_RD;
      IASID_RD:
        if (jtlb_rsp.grant)
          iasid_nxt = IASID_RWC;
      IASID_RWC:
      begin
        if (rd_cmplt && jtlb_rsp.asid_hit)
          iasid_nxt = IASID_WT;
        else if (rd_cmplt)
          iasid_nxt = cnt_zero ? IASID_IDLE : IASID_RD;
      end
      IASID_WT:
        if (jtlb_rsp.grant)
          iasid_nxt = cnt_zero ? IASID_WWC : IASID_RD;
      IASID_WWC:
        if (jtlb_rsp.cmplt)
          iasid_nxt = IASID_IDLE;
      default:
        iasid_nxt = IASID_IDLE;
    endcase
  end

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      iall_st  <= IALL_IDLE;
      iasid_st <= IASID_IDLE;
    end
    else
    begin
      iall_st  <= iall_nxt;
      iasid_st <= iasid_nxt;
    end
  end

  // ====================
  // shared index counter
  // ====================
  assign cnt_init = (iall_st == IALL_IDLE) && start_all
                 || (iasid_st == IASID_IDLE) && start_asid;
  assign cnt_dec  = !cnt_zero
                 && ((iall_st == IALL_WFG) && jtlb_rsp.grant
                  || (iasid_st == IASID_RWC) && rd_cmplt && !jtlb_rsp.asid_hit
                  || (iasid_st == IASID_WT) && jtlb_rsp.grant);

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inv_cnt <= '0;
    else if (cnt_init)
      inv_cnt <= start_all ? tlb_maint_pkg::IDX_WIDTH'(INVALL_LAST)
                           : tlb_maint_pkg::IDX_WIDTH'(INVASID_LAST);
    else if (cnt_dec)
      inv_cnt <= inv_cnt - 1'b1;
  end

  // request toward the builder
  assign seq_req.req        = (iall_st == IALL_WFG) || (iasid_st == IASID_RD)
                           || (iasid_st == IASID_WT);
  assign seq_req.write      = (iall_st == IALL_WFG) || (iasid_st == IASID_WT);
  assign seq_req.fifo_write = (iall_st == IALL_WFG);
  assign seq_req.idx        = inv_cnt;
  assign seq_req.src_sweep  = 1'b1;

  assign busy = (iall_st != IALL_IDLE) || (iasid_st != IASID_IDLE);
  assign done = (iall_st == IALL_FIN) && jtlb_rsp.cmplt
             || (iasid_st == IASID_RWC) && rd_cmplt && !jtlb_rsp.asid_hit && cnt_zero
             || (iasid_st == IASID_WWC) && jtlb_rsp.cmplt;

  // counter only leaves zero by a fresh load
  a_cnt_no_wrap: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (cnt_zero && !cnt_init) |=> cnt_zero)
    else $error("sweep: index counter wrapped below zero");

endmodule

/* hw/tlb_write_seq.sv */
// ====================
// write-indexed sequencer, one jTLB write at the captured index
// best case start to done is 3 cycles
// ====================
`timescale 1ns/1ps

module tlb_write_seq (
  input  logic                                      tlboper_clk,
  input  logic                                      cpurst_b,
  input  logic                                      start_wi,
  input  logic [tlb_maint_pkg::IDX_WIDTH-1:0]       regs_mir,
  input  tlb_maint_pkg::jtlb_rsp_t                  jtlb_rsp,
  output tlb_maint_pkg::seq_req_t                   seq_req,
  output logic                                      busy,
  output logic                                      done
);

  typedef enum logic [1:0] {
    WI_IDLE = 2'b00,
    WI_WFG  = 2'b01,
    WI_WFC  = 2'b11
  } wi_st_e;

  wi_st_e                                wi_st;
  wi_st_e                                wi_nxt;
  logic [tlb_maint_pkg::IDX_WIDTH-1:0]   wi_idx;

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wi_st <= WI_IDLE;
    else
      wi_st <= wi_nxt;
  end

  always_comb
  begin
    wi_nxt = wi_st;
    case (wi_st)
      WI_IDLE:
        if (start_wi)
          wi_nxt = WI_WFG;
      WI_WFG:
        if (jtlb_rsp.grant)
          wi_nxt = WI_WFC;
      WI_WFC:
        if (jtlb_rsp.cmplt)
          wi_nxt = WI_IDLE;
      default:
        wi_nxt = WI_IDLE;
    endcase
  end

  // index held for the whole request
  always_ff @(posedge tlboper_clk)
  begin
    if (start_wi)
      wi_idx <= regs_mir;
  end

  assign seq_req.req        = (wi_st == WI_WFG);
  assign seq_req.write      = 1'b1;
  assign seq_req.fifo_write = 1'b0;
  assign seq_req.idx        = wi_idx;
  assign seq_req.src_sweep  = 1'b0;

  assign busy = (wi_st != WI_IDLE);
  assign done = (wi_st == WI_WFC) && jtlb_rsp.cmplt;

endmodule

/* hw/tlb_cmd_accept.sv */
// ====================
// picks one maintenance operation when all sequencers are idle
// CP0 levels win and block register levels while high
// CP0 levels are held until cp0_inv_done, register levels until regs_cmplt
// ====================
`timescale 1ns/1ps

module tlb_cmd_accept (
  input  logic                    tlboper_clk,
  input  logic                    cpurst_b,
  input  logic                    regs_tlbwi,
  input  logic                    regs_invall,
  input  logic                    regs_invasid,
  input  logic                    cp0_all_inv,
  input  logic                    cp0_asid_inv,
  input  logic                    wi_busy,
  input  logic                    sweep_busy,
  input  logic                    wi_done,
  input  logic                    sweep_done,
  output tlb_maint_pkg::tlb_start_t start,
  output logic                    cmplt,
  output logic                    regs_cmplt,
  output logic                    cp0_inv_done
);

  logic                  pipe_idle;
  logic                  cp0_any;
  logic                  cp0_start;
  logic                  cp0_owner;
  tlb_maint_pkg::tlb_op_e sel_op;

  assign pipe_idle = !wi_busy && !sweep_busy;
  assign cp0_any   = cp0_all_inv || cp0_asid_inv;
  // held CP0 level must not restart in the done cycle
  assign cp0_start = pipe_idle && cp0_any && !cp0_inv_done;

  // ====================
  // operation select
  // ====================
  always_comb
  begin
    sel_op = tlb_maint_pkg::OP_NONE;
    if (cp0_start)
    begin
      if (cp0_all_inv)
        sel_op = tlb_maint_pkg::OP_INV_ALL;
      else
        sel_op = tlb_maint_pkg::OP_INV_ASID;
    end
    else if (pipe_idle && !cp0_any)
    begin
      if (regs_tlbwi)
        sel_op = tlb_maint_pkg::OP_WRITE_IDX;
      else if (regs_invall)
        sel_op = tlb_maint_pkg::OP_INV_ALL;
      else if (regs_invasid)
        sel_op = tlb_maint_pkg::OP_INV_ASID;
    end
  end

  assign start.start_wi   = (sel_op == tlb_maint_pkg::OP_WRITE_IDX);
  assign start.start_all  = (sel_op == tlb_maint_pkg::OP_INV_ALL);
  assign start.start_asid = (sel_op == tlb_maint_pkg::OP_INV_ASID);

  // ====================
  // completion
  // ====================
  assign cmplt      = wi_done || sweep_done;
  assign regs_cmplt = cmplt && !cp0_owner;

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cp0_owner <= 1'b0;
    else if (cp0_start)
      cp0_owner <= 1'b1;
    else if (cmplt)
      cp0_owner <= 1'b0;
  end

  // one cycle after the CP0-owned completion
  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cp0_inv_done <= 1'b0;
    else
      cp0_inv_done <= cmplt && cp0_owner;
  end

  a_start_onehot: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    $onehot0(start))
    else $error("accept: more than one start strobe");

  // a sequencer must pick up every strobe it is sent
  a_start_busy: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (start != '0) |=> (wi_busy || sweep_busy))
    else $error("accept: start strobe not taken by a sequencer");

endmodule

/* hw/tlb_maint_pkg.sv */
// ====================
// shared widths and bus structs for the jTLB maintenance sequencer
// jTLB is 512 entries in two banks chosen by index bit 6
// jtlb_req_t adds up to 108 bits from its fields
// ====================

package tlb_maint_pkg;

  // ====================
  // widths
  // ====================
  localparam int unsigned VPN_WIDTH  = 27;
  localparam int unsigned PPN_WIDTH  = 28;
  localparam int unsigned ASID_WIDTH = 16;
  localparam int unsigned FLG_WIDTH  = 16;
  localparam int unsigned PGS_WIDTH  = 3;
  localparam int unsigned IDX_WIDTH  = 9;
  // index bit that selects the bank
  localparam int unsigned BANK_BIT   = 6;

  // ====================
  // entry formats
  // ====================
  typedef struct packed {
    logic                  valid;
    logic [VPN_WIDTH-1:0]  vpn;
    logic [ASID_WIDTH-1:0] asid;
    logic [PGS_WIDTH-1:0]  pgs;
    logic                  global;
  } tlb_tag_t;

  typedef struct packed {
    logic [PPN_WIDTH-1:0] ppn;
    logic [FLG_WIDTH-1:0] flg;
  } tlb_data_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_WRITE_IDX,
    OP_INV_ALL,
    OP_INV_ASID
  } tlb_op_e;

  // ====================
  // internal and jTLB buses
  // ====================
  // one-cycle strobes from accept stage
  typedef struct packed {
    logic start_wi;
    logic start_all;
    logic start_asid;
  } tlb_start_t;

  // request of one sequencer
  typedef struct packed {
    logic                 req;
    logic                 write;
    logic                 fifo_write;
    logic [IDX_WIDTH-1:0] idx;
    logic                 src_sweep;
  } seq_req_t;

  typedef struct packed {
    logic                 req;
    logic                 write;
    logic                 fifo_write;
    logic [1:0]           fifo_din;
    logic [IDX_WIDTH-1:0] idx;
    logic [1:0]           bank_sel;
    tlb_tag_t             tag;
    tlb_data_t            data;
  } jtlb_req_t;

  typedef struct packed {
    logic grant;
    logic cmplt;
    logic tc_read;
    logic asid_hit;
  } jtlb_rsp_t;

endpackage
